// ==== flist.f ====
logic/core_pkg.sv
logic/reg_file.sv
logic/issue_stage.sv
logic/hazard_ctrl.sv
logic/fwd_mux.sv
logic/exec_stage.sv
logic/fwd_core.sv
test/tb_clock.sv
test/fwd_core_tb.sv

// ==== test/fwd_core_tb.sv ====
`timescale 1ns/1ns

module fwd_core_tb import core_pkg::*; ();

    localparam int RESET_TIMEOUT = 20;
    localparam int NUM_RANDOM    = 2000;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
        logic     cp0_we;
        cp0_sel_t cp0_sel;
        word_t    cp0_data;
    } wb_expect_t;

    logic     clk;
    logic     reset;
    logic     issue;
    op_t      op;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    imm_t     imm;
    cp0_sel_t cp0_sel;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     cp0_we;
    cp0_sel_t cp0_sel_w;
    word_t    cp0_data_w;

    word_t       model_rf [NUM_REGS];
    word_t       model_cp0 [2];
    wb_expect_t  exp_q [$];
    logic [15:0] lfsr;
    string       test_name;
    int          issued;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    fwd_core uut (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .op         (op),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .imm        (imm),
        .cp0_sel    (cp0_sel),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .cp0_we     (cp0_we),
        .cp0_sel_w  (cp0_sel_w),
        .cp0_data_w (cp0_data_w)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t take_bits(int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic check_field(string what, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // in-order reference applied at issue
    task automatic model_execute(op_t o, reg_idx_t s, reg_idx_t t, reg_idx_t d,
                                 imm_t i, cp0_sel_t c, output wb_expect_t e);
        word_t a;
        word_t b;
        e = '0;
        a = (s == '0) ? '0 : model_rf[s];
        b = (t == '0) ? '0 : model_rf[t];
        e.rd = d;
        case (o)
            OP_ADD:  e.data = a + b;
            OP_LI:   e.data = {16'h0000, i};
            OP_MFC0: e.data = model_cp0[c];
            default: e.data = '0;
        endcase
        e.we = (o == OP_ADD || o == OP_LI || o == OP_MFC0) && d != '0;
        if (e.we)
            model_rf[d] = e.data;
        if (o == OP_MTC0) begin
            e.cp0_we     = 1'b1;
            e.cp0_sel    = c;
            e.cp0_data   = a;
            model_cp0[c] = a;
        end
    endtask

    task automatic check_front();
        wb_expect_t e;
        e = exp_q.pop_front();
        check_field("wb_we", word_t'(e.we), word_t'(wb_we));
        if (e.we) begin
            check_field("wb_rd", word_t'(e.rd), word_t'(wb_rd));
            check_field("wb_data", e.data, wb_data);
        end
        check_field("cp0_we", word_t'(e.cp0_we), word_t'(cp0_we));
        if (e.cp0_we) begin
            check_field("cp0_sel_w", word_t'(e.cp0_sel), word_t'(cp0_sel_w));
            check_field("cp0_data_w", e.cp0_data, cp0_data_w);
        end
    endtask

    // check the due slot then drive the next input
    task automatic run_cycle(logic v, op_t o, reg_idx_t s, reg_idx_t t, reg_idx_t d,
                             imm_t i, cp0_sel_t c);
        wb_expect_t e;
        @(posedge clk);
        #1;
        check_front();
        issue   = v;
        op      = o;
        rs      = s;
        rt      = t;
        rd      = d;
        imm     = i;
        cp0_sel = c;
        e = '0;
        if (v) begin
            model_execute(o, s, t, d, i, c, e);
            issued++;
        end
        exp_q.push_back(e);
    endtask

    task automatic send(op_t o, reg_idx_t s, reg_idx_t t, reg_idx_t d, imm_t i,
                        cp0_sel_t c);
        run_cycle(1'b1, o, s, t, d, i, c);
    endtask

    task automatic bubble();
        run_cycle(1'b0, op, rs, rt, rd, imm, cp0_sel);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > RESET_TIMEOUT) begin
                $display("reset still asserted after %0d cycles", RESET_TIMEOUT);
                $display("*** FAILED ***");
                $fatal(1, "reset timeout");
            end
        end
    endtask

    task automatic random_instr();
        word_t    pick;
        op_t      o;
        logic     v;
        reg_idx_t s;
        reg_idx_t t;
        reg_idx_t d;
        imm_t     i;
        cp0_sel_t c;
        v    = take_bits(8) >= 51;   // roughly one bubble in five
        pick = take_bits(3);
        case (pick)
            0, 1, 2: o = OP_ADD;
            3, 4:    o = OP_LI;
            5:       o = OP_MTC0;
            6:       o = OP_MFC0;
            default: o = OP_NOP;
        endcase
        s = reg_idx_t'(take_bits(2));   // r0..r3 keeps hazards dense
        t = reg_idx_t'(take_bits(2));
        d = reg_idx_t'(take_bits(2));
        i = imm_t'(take_bits(16));
        c = cp0_sel_t'(take_bits(1));
        run_cycle(v, o, s, t, d, i, c);
    endtask

    initial begin
        issue   = 1'b0;
        op      = OP_NOP;
        rs      = '0;
        rt      = '0;
        rd      = '0;
        imm     = '0;
        cp0_sel = CP0_IE;
        lfsr    = 16'd55950;
        issued  = 0;
        for (int k = 0; k < NUM_REGS; k++)
            model_rf[k] = '0;
        model_cp0[0] = '0;
        model_cp0[1] = '0;
        repeat (ISSUE_TO_WB) exp_q.push_back('0);   // nothing in flight after reset

        wait_reset_release();

        test_name = "reset_idle";
        repeat (3) bubble();
        send(OP_MFC0, 0, 0, 1, 0, CP0_IE);
        send(OP_MFC0, 0, 0, 2, 0, CP0_EPC);

        test_name = "fwd_ma_wb";
        send(OP_LI, 0, 0, 1, 16'h0005, CP0_IE);
        send(OP_LI, 0, 0, 2, 16'h0007, CP0_IE);
        send(OP_ADD, 1, 2, 3, 0, CP0_IE);   // r2 from MA and r1 from WB
        send(OP_ADD, 3, 3, 1, 0, CP0_IE);
        send(OP_ADD, 3, 1, 2, 0, CP0_IE);
        send(OP_LI, 0, 0, 1, 16'h0011, CP0_IE);
        send(OP_LI, 0, 0, 1, 16'h0022, CP0_IE);
        send(OP_ADD, 1, 0, 2, 0, CP0_IE);   // MA and WB both hold r1

        test_name = "write_through";
        send(OP_LI, 0, 0, 3, 16'h1234, CP0_IE);
        bubble();
        bubble();
        send(OP_ADD, 3, 0, 1, 0, CP0_IE);
        send(OP_LI, 0, 0, 0, 16'hffff, CP0_IE);
        send(OP_ADD, 0, 0, 2, 0, CP0_IE);
        send(OP_ADD, 0, 3, 1, 0, CP0_IE);

        test_name = "cp0_fwd";
        send(OP_LI, 0, 0, 1, 16'haaaa, CP0_IE);
        send(OP_MTC0, 1, 0, 0, 0, CP0_IE);
        send(OP_MFC0, 0, 0, 2, 0, CP0_IE);    // from EX
        send(OP_MFC0, 0, 0, 3, 0, CP0_EPC);   // other register untouched
        send(OP_LI, 0, 0, 1, 16'h5555, CP0_IE);
        send(OP_MTC0, 1, 0, 0, 0, CP0_EPC);
        bubble();
        send(OP_MFC0, 0, 0, 2, 0, CP0_EPC);   // from MA
        send(OP_MFC0, 0, 0, 3, 0, CP0_IE);
        send(OP_MTC0, 2, 0, 0, 0, CP0_IE);
        bubble();
        bubble();
        send(OP_MFC0, 0, 0, 1, 0, CP0_IE);    // WB write-through

        test_name = "random_stream";
        issued = 0;
        while (issued < NUM_RANDOM)
            random_instr();

        test_name = "drain";
        repeat (ISSUE_TO_WB) bubble();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;   // released on the third edge
    end

endmodule

// ==== logic/fwd_core.sv ====
`timescale 1ns/1ns

module fwd_core import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     issue,
    input  op_t      op,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    input  imm_t     imm,
    input  cp0_sel_t cp0_sel,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     cp0_we,
    output cp0_sel_t cp0_sel_w,
    output word_t    cp0_data_w
);

    reg_idx_t id_rs;
    reg_idx_t id_rt;
    cp0_sel_t id_cp0_sel;
    logic     id_reads_cp0;
    word_t    rf_data_a;
    word_t    rf_data_b;
    word_t    rc0_ie;
    word_t    rc0_epc;
    word_t    id_fwd_rc0_ie;
    word_t    id_fwd_rc0_epc;

    logic     ex_valid;
    op_t      ex_op;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;
    reg_idx_t ex_rd;
    imm_t     ex_imm;
    cp0_sel_t ex_cp0_sel;
    word_t    ex_rf_data_a;
    word_t    ex_rf_data_b;
    word_t    ex_rc0_val;
    word_t    ex_fwd_rf_a;
    word_t    ex_fwd_rf_b;
    logic     ex_writes_cp0;
    word_t    ex_val_rc0_ie_w;
    word_t    ex_val_rc0_epc_w;

    logic     ma_valid;
    reg_idx_t ma_rd;
    logic     ma_writes_rf;
    logic     ma_writes_cp0;
    cp0_sel_t ma_cp0_sel;
    word_t    ma_val_rf_w_tmp;
    word_t    ma_val_rc0_ie_w;
    word_t    ma_val_rc0_epc_w;

    fwd_rf_t  mux_fwd_rf_a;
    fwd_rf_t  mux_fwd_rf_b;
    fwd_rc0_t mux_fwd_rc0_ie;
    fwd_rc0_t mux_fwd_rc0_epc;

    reg_file u_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs         (id_rs),
        .rt         (id_rt),
        .cp0_sel_rd (id_cp0_sel),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .cp0_we     (cp0_we),
        .cp0_sel_w  (cp0_sel_w),
        .cp0_data_w (cp0_data_w),
        .rf_data_a  (rf_data_a),
        .rf_data_b  (rf_data_b),
        .rc0_ie     (rc0_ie),
        .rc0_epc    (rc0_epc)
    );

    issue_stage u_issue_stage (
        .clk            (clk),
        .reset          (reset),
        .issue          (issue),
        .op             (op),
        .rs             (rs),
        .rt             (rt),
        .rd             (rd),
        .imm            (imm),
        .cp0_sel        (cp0_sel),
        .rf_data_a      (rf_data_a),
        .rf_data_b      (rf_data_b),
        .id_fwd_rc0_ie  (id_fwd_rc0_ie),
        .id_fwd_rc0_epc (id_fwd_rc0_epc),
        .id_rs          (id_rs),
        .id_rt          (id_rt),
        .id_cp0_sel     (id_cp0_sel),
        .id_reads_cp0   (id_reads_cp0),
        .ex_valid       (ex_valid),
        .ex_op          (ex_op),
        .ex_rs          (ex_rs),
        .ex_rt          (ex_rt),
        .ex_rd          (ex_rd),
        .ex_imm         (ex_imm),
        .ex_cp0_sel     (ex_cp0_sel),
        .ex_rf_data_a   (ex_rf_data_a),
        .ex_rf_data_b   (ex_rf_data_b),
        .ex_rc0_val     (ex_rc0_val)
    );

    hazard_ctrl u_hazard_ctrl (
        .ex_rs           (ex_rs),
        .ex_rt           (ex_rt),
        .id_cp0_sel      (id_cp0_sel),
        .id_reads_cp0    (id_reads_cp0),
        .ex_valid        (ex_valid),
        .ex_writes_cp0   (ex_writes_cp0),
        .ex_cp0_sel      (ex_cp0_sel),
        .ma_valid        (ma_valid),
        .ma_rd           (ma_rd),
        .ma_writes_rf    (ma_writes_rf),
        .ma_writes_cp0   (ma_writes_cp0),
        .ma_cp0_sel      (ma_cp0_sel),
        .wb_we           (wb_we),
        .wb_rd           (wb_rd),
        .mux_fwd_rf_a    (mux_fwd_rf_a),
        .mux_fwd_rf_b    (mux_fwd_rf_b),
        .mux_fwd_rc0_ie  (mux_fwd_rc0_ie),
        .mux_fwd_rc0_epc (mux_fwd_rc0_epc)
    );

    fwd_mux u_fwd_mux (
        .mux_fwd_rf_a     (mux_fwd_rf_a),
        .mux_fwd_rf_b     (mux_fwd_rf_b),
        .mux_fwd_rc0_ie   (mux_fwd_rc0_ie),
        .mux_fwd_rc0_epc  (mux_fwd_rc0_epc),
        .ex_rf_data_a     (ex_rf_data_a),
        .ex_rf_data_b     (ex_rf_data_b),
        .ma_val_rf_w_tmp  (ma_val_rf_w_tmp),
        .wb_val_rf_data_w (wb_data),
        .rc0_ie           (rc0_ie),
        .rc0_epc          (rc0_epc),
        .ex_val_rc0_ie_w  (ex_val_rc0_ie_w),
        .ex_val_rc0_epc_w (ex_val_rc0_epc_w),
        .ma_val_rc0_ie_w  (ma_val_rc0_ie_w),
        .ma_val_rc0_epc_w (ma_val_rc0_epc_w),
        .ex_fwd_rf_a      (ex_fwd_rf_a),
        .ex_fwd_rf_b      (ex_fwd_rf_b),
        .id_fwd_rc0_ie    (id_fwd_rc0_ie),
        .id_fwd_rc0_epc   (id_fwd_rc0_epc)
    );

    exec_stage u_exec_stage (
        .clk              (clk),
        .reset            (reset),
        .ex_valid         (ex_valid),
        .ex_op            (ex_op),
        .ex_rd            (ex_rd),
        .ex_imm           (ex_imm),
        .ex_cp0_sel       (ex_cp0_sel),
        .ex_rc0_val       (ex_rc0_val),
        .ex_fwd_rf_a      (ex_fwd_rf_a),
        .ex_fwd_rf_b      (ex_fwd_rf_b),
        .ex_writes_cp0    (ex_writes_cp0),
        .ex_val_rc0_ie_w  (ex_val_rc0_ie_w),
        .ex_val_rc0_epc_w (ex_val_rc0_epc_w),
        .ma_valid         (ma_valid),
        .ma_rd            (ma_rd),
        .ma_writes_rf     (ma_writes_rf),
        .ma_writes_cp0    (ma_writes_cp0),
        .ma_cp0_sel       (ma_cp0_sel),
        .ma_val_rf_w_tmp  (ma_val_rf_w_tmp),
        .ma_val_rc0_ie_w  (ma_val_rc0_ie_w),
        .ma_val_rc0_epc_w (ma_val_rc0_epc_w),
        .wb_we            (wb_we),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data),
        .cp0_we           (cp0_we),
        .cp0_sel_w        (cp0_sel_w),
        .cp0_data_w       (cp0_data_w)
    );

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ns

module exec_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ex_valid,
    input  op_t      ex_op,
    input  reg_idx_t ex_rd,
    input  imm_t     ex_imm,
    input  cp0_sel_t ex_cp0_sel,
    input  word_t    ex_rc0_val,
    input  word_t    ex_fwd_rf_a,
    input  word_t    ex_fwd_rf_b,
    output logic     ex_writes_cp0,
    output word_t    ex_val_rc0_ie_w,
    output word_t    ex_val_rc0_epc_w,
    output logic     ma_valid,
    output reg_idx_t ma_rd,
    output logic     ma_writes_rf,
    output logic     ma_writes_cp0,
    output cp0_sel_t ma_cp0_sel,
    output word_t    ma_val_rf_w_tmp,
    output word_t    ma_val_rc0_ie_w,
    output word_t    ma_val_rc0_epc_w,
    output logic     wb_we,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     cp0_we,
    output cp0_sel_t cp0_sel_w,
    output word_t    cp0_data_w
);

    word_t ex_result;
    logic  ex_writes_rf;

    always_comb begin
        case (ex_op)
            OP_ADD:  ex_result = ex_fwd_rf_a + ex_fwd_rf_b;
            OP_LI:   ex_result = word_t'(ex_imm);   // zero extend
            OP_MFC0: ex_result = ex_rc0_val;
            OP_MTC0: ex_result = ex_fwd_rf_a;       // new cp0 value
            default: ex_result = '0;
        endcase
    end

    assign ex_writes_rf  = op_writes_rf(ex_op) && (ex_rd != '0);
    assign ex_writes_cp0 = ex_op == OP_MTC0;

    // untargeted lane keeps the cp0 operand seen by this instruction
    assign ex_val_rc0_ie_w  = (ex_writes_cp0 && ex_cp0_sel == CP0_IE) ?
                              ex_fwd_rf_a : ex_rc0_val;
    assign ex_val_rc0_epc_w = (ex_writes_cp0 && ex_cp0_sel == CP0_EPC) ?
                              ex_fwd_rf_a : ex_rc0_val;

    always_ff @(posedge clk) begin
        if (reset)
            ma_valid <= 1'b0;
        else
            ma_valid <= ex_valid;
    end

    always_ff @(posedge clk) begin
        ma_rd            <= ex_rd;
        ma_writes_rf     <= ex_writes_rf;
        ma_writes_cp0    <= ex_writes_cp0;
        ma_cp0_sel       <= ex_cp0_sel;
        ma_val_rf_w_tmp  <= ex_result;
        ma_val_rc0_ie_w  <= ex_val_rc0_ie_w;
        ma_val_rc0_epc_w <= ex_val_rc0_epc_w;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we  <= 1'b0;
            cp0_we <= 1'b0;
        end else begin
            wb_we  <= ma_valid && ma_writes_rf;
            cp0_we <= ma_valid && ma_writes_cp0;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd      <= ma_rd;
        wb_data    <= ma_val_rf_w_tmp;
        cp0_sel_w  <= ma_cp0_sel;
        cp0_data_w <= ma_val_rf_w_tmp;
    end

    a_no_wb_r0: assert property (@(posedge clk) disable iff (reset)
        wb_we |-> wb_rd != '0);

endmodule

// ==== logic/fwd_mux.sv ====
`timescale 1ns/1ns

module fwd_mux import core_pkg::*; (
    input  fwd_rf_t  mux_fwd_rf_a,
    input  fwd_rf_t  mux_fwd_rf_b,
    input  fwd_rc0_t mux_fwd_rc0_ie,
    input  fwd_rc0_t mux_fwd_rc0_epc,
    input  word_t    ex_rf_data_a,
    input  word_t    ex_rf_data_b,
    input  word_t    ma_val_rf_w_tmp,
    input  word_t    wb_val_rf_data_w,
    input  word_t    rc0_ie,
    input  word_t    rc0_epc,
    input  word_t    ex_val_rc0_ie_w,
    input  word_t    ex_val_rc0_epc_w,
    input  word_t    ma_val_rc0_ie_w,
    input  word_t    ma_val_rc0_epc_w,
    output word_t    ex_fwd_rf_a,
    output word_t    ex_fwd_rf_b,
    output word_t    id_fwd_rc0_ie,
    output word_t    id_fwd_rc0_epc
);

    function automatic word_t pick_rf(fwd_rf_t sel, word_t norm, word_t tmp, word_t dat);
        case (sel)
            FWD_RF_TMP: return tmp;
            FWD_RF_DAT: return dat;
            default:    return norm;   // NORM and the spare code
        endcase
    endfunction

    function automatic word_t pick_rc0(fwd_rc0_t sel, word_t norm, word_t ex, word_t ma);
        case (sel)
            FWD_RC0_EX: return ex;
            FWD_RC0_MA: return ma;
            default:    return norm;
        endcase
    endfunction

    always_comb begin
        ex_fwd_rf_a    = pick_rf(mux_fwd_rf_a, ex_rf_data_a, ma_val_rf_w_tmp,
                                 wb_val_rf_data_w);
        ex_fwd_rf_b    = pick_rf(mux_fwd_rf_b, ex_rf_data_b, ma_val_rf_w_tmp,
                                 wb_val_rf_data_w);
        id_fwd_rc0_ie  = pick_rc0(mux_fwd_rc0_ie, rc0_ie, ex_val_rc0_ie_w,
                                  ma_val_rc0_ie_w);
        id_fwd_rc0_epc = pick_rc0(mux_fwd_rc0_epc, rc0_epc, ex_val_rc0_epc_w,
                                  ma_val_rc0_epc_w);
    end

endmodule

// ==== logic/hazard_ctrl.sv ====
`timescale 1ns/1ns

module hazard_ctrl import core_pkg::*; (
    input  reg_idx_t ex_rs,
    input  reg_idx_t ex_rt,
    input  cp0_sel_t id_cp0_sel,
    input  logic     id_reads_cp0,
    input  logic     ex_valid,
    input  logic     ex_writes_cp0,
    input  cp0_sel_t ex_cp0_sel,
    input  logic     ma_valid,
    input  reg_idx_t ma_rd,
    input  logic     ma_writes_rf,
    input  logic     ma_writes_cp0,
    input  cp0_sel_t ma_cp0_sel,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    output fwd_rf_t  mux_fwd_rf_a,
    output fwd_rf_t  mux_fwd_rf_b,
    output fwd_rc0_t mux_fwd_rc0_ie,
    output fwd_rc0_t mux_fwd_rc0_epc
);

    logic ma_rf_hit_ok;
    logic ex_cp0_pend;
    logic ma_cp0_pend;

    assign ma_rf_hit_ok = ma_valid && ma_writes_rf;
    assign ex_cp0_pend  = ex_valid && ex_writes_cp0;
    assign ma_cp0_pend  = ma_valid && ma_writes_cp0;

    // newest producer first
    function automatic fwd_rf_t rf_select(reg_idx_t src);
        if (ma_rf_hit_ok && ma_rd == src)
            return FWD_RF_TMP;
        if (wb_we && wb_rd == src)
            return FWD_RF_DAT;
        return FWD_RF_NORM;
    endfunction

    function automatic fwd_rc0_t rc0_select(cp0_sel_t lane);
        if (!id_reads_cp0 || id_cp0_sel != lane)
            return FWD_RC0_NORM;
        if (ex_cp0_pend && ex_cp0_sel == lane)
            return FWD_RC0_EX;
        if (ma_cp0_pend && ma_cp0_sel == lane)
            return FWD_RC0_MA;
        return FWD_RC0_NORM;   // WB write reaches ID by write-through
    endfunction

    always_comb begin
        mux_fwd_rf_a    = rf_select(ex_rs);
        mux_fwd_rf_b    = rf_select(ex_rt);
        mux_fwd_rc0_ie  = rc0_select(CP0_IE);
        mux_fwd_rc0_epc = rc0_select(CP0_EPC);
    end

    always_comb begin
        a_no_fwd_r0: assert final (
            (ex_rs != '0 || mux_fwd_rf_a == FWD_RF_NORM) &&
            (ex_rt != '0 || mux_fwd_rf_b == FWD_RF_NORM));
    end

endmodule

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ns

module issue_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     issue,
    input  op_t      op,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t rd,
    input  imm_t     imm,
    input  cp0_sel_t cp0_sel,
    input  word_t    rf_data_a,
    input  word_t    rf_data_b,
    input  word_t    id_fwd_rc0_ie,
    input  word_t    id_fwd_rc0_epc,
    output reg_idx_t id_rs,
    output reg_idx_t id_rt,
    output cp0_sel_t id_cp0_sel,
    output logic     id_reads_cp0,
    output logic     ex_valid,
    output op_t      ex_op,
    output reg_idx_t ex_rs,
    output reg_idx_t ex_rt,
    output reg_idx_t ex_rd,
    output imm_t     ex_imm,
    output cp0_sel_t ex_cp0_sel,
    output word_t    ex_rf_data_a,
    output word_t    ex_rf_data_b,
    output word_t    ex_rc0_val
);

    logic     id_valid;
    op_t      id_op;
    reg_idx_t id_rs_raw;
    reg_idx_t id_rt_raw;
    reg_idx_t id_rd;
    imm_t     id_imm;

    always_ff @(posedge clk) begin
        if (reset)
            id_valid <= 1'b0;
        else
            id_valid <= issue;   // no issue means a bubble
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            id_op      <= op;
            id_rs_raw  <= rs;
            id_rt_raw  <= rt;
            id_rd      <= rd;
            id_imm     <= imm;
            id_cp0_sel <= cp0_sel;
        end
    end

    // unused sources become r0 so they never match a producer
    assign id_rs        = (id_valid && op_reads_rs(id_op)) ? id_rs_raw : '0;
    assign id_rt        = (id_valid && op_reads_rt(id_op)) ? id_rt_raw : '0;
    assign id_reads_cp0 = id_valid && (id_op == OP_MFC0);

    always_ff @(posedge clk) begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= id_valid;
    end

    always_ff @(posedge clk) begin
        ex_op        <= id_op;
        ex_rs        <= id_rs;
        ex_rt        <= id_rt;
        ex_rd        <= id_rd;
        ex_imm       <= id_imm;
        ex_cp0_sel   <= id_cp0_sel;
        ex_rf_data_a <= rf_data_a;
        ex_rf_data_b <= rf_data_b;
        ex_rc0_val   <= (id_cp0_sel == CP0_IE) ? id_fwd_rc0_ie : id_fwd_rc0_epc;
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  cp0_sel_t cp0_sel_rd,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data,
    input  logic     cp0_we,
    input  cp0_sel_t cp0_sel_w,
    input  word_t    cp0_data_w,
    output word_t    rf_data_a,
    output word_t    rf_data_b,
    output word_t    rc0_ie,
    output word_t    rc0_epc
);

    word_t regs [NUM_REGS];
    word_t cp0_ie;
    word_t cp0_epc;

    function automatic word_t read_port(reg_idx_t idx);
        if (wb_we && wb_rd == idx)
            return wb_data;   // same-cycle write-through
        return regs[idx];     // r0 stays zero from reset
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            cp0_ie  <= '0;
            cp0_epc <= '0;
        end else begin
            if (wb_we && wb_rd != '0)
                regs[wb_rd] <= wb_data;
            if (cp0_we && cp0_sel_w == CP0_IE)
                cp0_ie <= cp0_data_w;
            if (cp0_we && cp0_sel_w == CP0_EPC)
                cp0_epc <= cp0_data_w;
        end
    end

    always_comb begin
        rf_data_a = read_port(rs);
        rf_data_b = read_port(rt);
    end

    // only the cp0 register being read in ID gets the bypass
    assign rc0_ie  = (cp0_we && cp0_sel_w == CP0_IE && cp0_sel_rd == CP0_IE) ?
                     cp0_data_w : cp0_ie;
    assign rc0_epc = (cp0_we && cp0_sel_w == CP0_EPC && cp0_sel_rd == CP0_EPC) ?
                     cp0_data_w : cp0_epc;

    a_zero_reg: assert property (@(posedge clk) disable iff (reset)
        (rs != '0 || rf_data_a == '0) && (rt != '0 || rf_data_b == '0));

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_IDX_W   = 5;
    localparam int IMM_W       = 16;
    localparam int NUM_REGS    = 32;
    localparam int ISSUE_TO_WB = 4;   // issue strobe to wb outputs, in cycles

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_LI,
        OP_MTC0,
        OP_MFC0
    } op_t;

    typedef logic cp0_sel_t;
    localparam cp0_sel_t CP0_IE  = 1'b0;
    localparam cp0_sel_t CP0_EPC = 1'b1;

    typedef logic [1:0] fwd_rf_t;
    localparam fwd_rf_t FWD_RF_NORM = 2'd0;   // operand read in ID
    localparam fwd_rf_t FWD_RF_TMP  = 2'd1;   // MA result
    localparam fwd_rf_t FWD_RF_DAT  = 2'd2;   // WB write data

    typedef logic [1:0] fwd_rc0_t;
    localparam fwd_rc0_t FWD_RC0_NORM = 2'd0;
    localparam fwd_rc0_t FWD_RC0_EX   = 2'd1;
    localparam fwd_rc0_t FWD_RC0_MA   = 2'd2;

    function automatic logic op_reads_rs(op_t op);
        return (op == OP_ADD) || (op == OP_MTC0);
    endfunction

    function automatic logic op_reads_rt(op_t op);
        return op == OP_ADD;
    endfunction

    function automatic logic op_writes_rf(op_t op);
        return (op == OP_ADD) || (op == OP_LI) || (op == OP_MFC0);
    endfunction

endpackage
